//--- tb.f
+incdir+source
source/pcie_dbg_pkg.sv
source/apb_slave_fsm.sv
source/capture_counter.sv
source/capture_buffer.sv
source/dbg_regs.sv
source/pcie_dbg_top.sv
verification/tb_clk_gen.sv
verification/pcie_dbg_checker.sv
verification/tb_pcie_dbg.sv

//--- Bender.yml
package:
  name: pcie_dbg

export_include_dirs:
  - source

sources:
  - files:
      - source/pcie_dbg_pkg.sv
      - source/apb_slave_fsm.sv
      - source/capture_counter.sv
      - source/capture_buffer.sv
      - source/dbg_regs.sv
      - source/pcie_dbg_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/pcie_dbg_checker.sv
      - verification/tb_pcie_dbg.sv

//--- verification/tb_pcie_dbg.sv
//##########################################################################
// PCIe debug block testbench
//##########################################################################

`include "pcie_dbg_defs.svh"

module tb_pcie_dbg;
    timeunit 1ns;
    timeprecision 1ps;
    import pcie_dbg_pkg::*;

    localparam int        TIMEOUT = 10;     // Access cycles before giving up
    localparam int        N_OPS   = 300;
    localparam apb_addr_t A_STATE = `PCIE_DBG_OFS_STATE;
    localparam apb_addr_t A_ID    = `PCIE_DBG_OFS_ID;
    localparam apb_addr_t A_COUNT = `PCIE_DBG_OFS_COUNT;
    localparam apb_addr_t A_BUF   = `PCIE_DBG_BUF_BASE;

    logic          clk;
    logic          nrst;
    apb_in_t       apb_in;
    apb_out_t      apb_out;
    dbg_req_t      dbg;
    dma_state_t    dma_state;
    completer_id_t cid;

    cap_data_t model_mem [`PCIE_DBG_CAP_DEPTH];   // Reference copy of the buffer
    logic      model_wr  [`PCIE_DBG_CAP_DEPTH];   // Slot written since reset
    cap_idx_t  model_cnt;
    integer    seed = 32'hab69;
    int        n_mismatch = 0;
    int        n_other = 0;

    tb_clk_gen #(.PERIOD(40)) u_tb_clk_gen (.o_clk(clk));

    pcie_dbg_top u_pcie_dbg_top (
        .i_clk          (clk),
        .i_nrst         (nrst),
        .i_apb          (apb_in),
        .o_apb          (apb_out),
        .i_dbg          (dbg),
        .i_dma_state    (dma_state),
        .i_completer_id (cid)
    );

    bind pcie_dbg_top pcie_dbg_checker u_pcie_dbg_checker (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_apb       (i_apb),
        .i_apb_rsp   (o_apb),
        .i_req_valid (bus_req.valid)
    );

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_count(input string name, input cap_idx_t got, input cap_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            n_mismatch++;
        end
    endtask

    // One capture into DUT and model at the current count slot
    task automatic push_capture(input cap_data_t d);
        dbg <= '{valid: 1'b1, data: d};
        model_mem[model_cnt] = d;
        model_wr[model_cnt]  = 1'b1;
        model_cnt            = model_cnt + 1'b1;    // Wraps 15 -> 0
    endtask

    task automatic capture_burst(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            push_capture({$random(seed), $random(seed)});
        end
        @(posedge clk);
        dbg.valid <= 1'b0;
    endtask

    // Full APB transfer with an optional capture in the request cycle
    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input logic clash);
        apb_data_t exp_data;
        apb_data_t got_data;
        logic      exp_err;
        logic      got_err;
        logic      known;
        logic      done;
        int        n;
        int        ofs;
        // Expected answer from the model as it stands before the strobe
        exp_data = '0;
        exp_err  = 1'b0;
        known    = 1'b1;
        ofs      = int'(addr) - int'(A_BUF);
        if (wr) begin
            exp_err = (addr != A_COUNT);
        end else if (addr == A_STATE) begin
            exp_data = {28'h0, dma_state};
        end else if (addr == A_ID) begin
            exp_data = {16'h0, cid};
        end else if (addr == A_COUNT) begin
            exp_data = {28'h0, model_cnt};
        end else if (ofs >= 0 && ofs < 128) begin
            known    = model_wr[ofs / 8];
            exp_data = (ofs % 8 == 4) ? model_mem[ofs / 8][63:32] : model_mem[ofs / 8][31:0];
        end else begin
            exp_err = 1'b1;
        end
        @(posedge clk);    // Setup phase
        apb_in <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: $random(seed)};
        @(posedge clk);
        apb_in.penable <= 1'b1;
        if (clash) begin
            push_capture({$random(seed), $random(seed)});
        end
        if (wr && addr == A_COUNT) begin
            model_cnt = '0;    // Clear beats the capture
        end
        n        = 0;
        done     = 1'b0;
        got_data = '0;
        got_err  = 1'b0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            if (apb_out.pready) begin
                done     = 1'b1;
                got_data = apb_out.prdata;
                got_err  = apb_out.pslverr;
            end else begin
                @(posedge clk);
                dbg.valid <= 1'b0;
            end
        end
        if (!done) begin
            $display("Timeout: no pready within %0d cycles at address 0x%03h", TIMEOUT, addr);
            n_other++;
        end else begin
            if (n != 2) begin
                $display("pready came in access cycle %0d instead of 2 at 0x%03h", n, addr);
                n_other++;
            end
            check_err("pslverr", got_err, exp_err);
            if (!wr && addr == A_COUNT) begin
                check_count("count", cap_idx_t'(got_data), cap_idx_t'(exp_data));
                check_data("prdata[31:4]", got_data >> 4, '0);
            end else if (known) begin
                check_data("prdata", got_data, exp_data);
            end
        end
        @(posedge clk);
        apb_in.psel    <= 1'b0;
        apb_in.penable <= 1'b0;
        dbg.valid      <= 1'b0;
    endtask

    initial begin
        int        i;
        int        op;
        logic      clash;
        apb_addr_t addr;
        nrst      = 1'b0;
        apb_in    = '0;
        dbg       = '0;
        dma_state = '0;
        cid       = '0;
        model_cnt = '0;
        for (i = 0; i < `PCIE_DBG_CAP_DEPTH; i++) begin
            model_wr[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        nrst <= 1'b1;

        // Wrap the buffer and read every slot back
        capture_burst(20);
        apb_xfer(A_COUNT, 1'b0, 1'b0);
        for (i = 0; i < `PCIE_DBG_CAP_DEPTH; i++) begin
            apb_xfer(A_BUF + apb_addr_t'(8 * i), 1'b0, 1'b0);
            apb_xfer(A_BUF + apb_addr_t'(8 * i + 4), 1'b0, 1'b0);
        end

        for (i = 0; i < N_OPS; i++) begin
            @(posedge clk);
            dma_state <= $random(seed);    // Only between transfers
            cid       <= $random(seed);
            capture_burst($unsigned($random(seed)) % 4);
            op    = $unsigned($random(seed)) % 8;
            clash = ($unsigned($random(seed)) % 6) == 0;
            case (op)
                0: apb_xfer(A_STATE, 1'b0, clash);
                1: apb_xfer(A_ID, 1'b0, clash);
                2: apb_xfer(A_COUNT, 1'b0, clash);
                3, 4: apb_xfer(A_BUF + apb_addr_t'($random(seed) & 'h7C), 1'b0, clash);
                5: apb_xfer(A_COUNT, 1'b1, clash);
                6: begin
                    // 0x0C..0x7C or 0x100..0xFFC
                    if ($random(seed) & 1) addr = 12'h00C + 4 * ($unsigned($random(seed)) % 29);
                    else addr = 12'h100 + 4 * ($unsigned($random(seed)) % 960);
                    apb_xfer(addr, 1'b0, clash);
                end
                default: begin
                    case ($unsigned($random(seed)) % 3)
                        0: addr = A_STATE;
                        1: addr = A_ID;
                        default: addr = A_BUF + apb_addr_t'($random(seed) & 'h7C);
                    endcase
                    apb_xfer(addr, 1'b1, clash);
                end
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 n_mismatch, n_other, u_pcie_dbg_top.u_pcie_dbg_checker.n_fail);
        if (n_mismatch == 0 && n_other == 0 && u_pcie_dbg_top.u_pcie_dbg_checker.n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verification/pcie_dbg_checker.sv
//##########################################################################
// APB protocol assertions
//##########################################################################

module pcie_dbg_checker (
    input logic                   i_clk,
    input logic                   i_nrst,
    input pcie_dbg_pkg::apb_in_t  i_apb,
    input pcie_dbg_pkg::apb_out_t i_apb_rsp,    // DUT's APB outputs
    input logic                   i_req_valid   // Internal request strobe
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_fail = 0;    // Failed assertion count

    // Ready only inside an access phase
    a_ready_in_access: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_apb_rsp.pready |-> (i_apb.psel && i_apb.penable))
        else begin
            n_fail++;
            $error("pready high outside an access phase");
        end

    a_err_with_ready: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_apb_rsp.pslverr |-> i_apb_rsp.pready)
        else begin
            n_fail++;
            $error("pslverr high without pready");
        end

    // One strobe per transfer
    a_req_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_valid |=> !i_req_valid)
        else begin
            n_fail++;
            $error("request strobe held for two cycles");
        end

    a_no_ready_in_reset: assert property (@(posedge i_clk)
        !i_nrst |-> !i_apb_rsp.pready)
        else begin
            n_fail++;
            $error("pready high during reset");
        end

endmodule

//--- verification/tb_clk_gen.sv
//##########################################################################
// Testbench clock
//##########################################################################

module tb_clk_gen #(
    parameter int PERIOD = 40    // ns
) (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial o_clk = 1'b0;
    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

//--- source/pcie_dbg_top.sv
//##########################################################################
// PCIe DMA debug and status block
//##########################################################################

module pcie_dbg_top (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  pcie_dbg_pkg::apb_in_t       i_apb,
    output pcie_dbg_pkg::apb_out_t      o_apb,
    input  pcie_dbg_pkg::dbg_req_t      i_dbg,          // Capture strobe and payload
    input  pcie_dbg_pkg::dma_state_t    i_dma_state,
    input  pcie_dbg_pkg::completer_id_t i_completer_id
);
    import pcie_dbg_pkg::*;

    bus_req_t  bus_req;
    bus_resp_t bus_resp;
    cap_idx_t  cap_idx;    // Write pointer and count
    cap_idx_t  rd_idx;
    cap_data_t rd_data;
    logic      cnt_clr;

    // APB front end
    apb_slave_fsm u_apb_slave_fsm (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_apb  (i_apb),
        .o_apb  (o_apb),
        .o_req  (bus_req),
        .i_resp (bus_resp)
    );

    capture_counter u_capture_counter (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_inc  (i_dbg.valid),
        .i_clr  (cnt_clr),
        .o_idx  (cap_idx)
    );

    // Captures land at the counter's slot
    capture_buffer u_capture_buffer (
        .i_clk     (i_clk),
        .i_wr      (i_dbg.valid),
        .i_wr_idx  (cap_idx),
        .i_wr_data (i_dbg.data),
        .i_rd_idx  (rd_idx),
        .o_rd_data (rd_data)
    );

    dbg_regs u_dbg_regs (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_req          (bus_req),
        .o_resp         (bus_resp),
        .i_dma_state    (i_dma_state),
        .i_completer_id (i_completer_id),
        .i_count        (cap_idx),
        .o_cnt_clr      (cnt_clr),
        .o_rd_idx       (rd_idx),
        .i_rd_data      (rd_data)
    );

endmodule

//--- source/dbg_regs.sv
//##########################################################################
// Debug register map decoder
//##########################################################################

`include "pcie_dbg_defs.svh"

module dbg_regs (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  pcie_dbg_pkg::bus_req_t      i_req,
    output pcie_dbg_pkg::bus_resp_t     o_resp,
    input  pcie_dbg_pkg::dma_state_t    i_dma_state,
    input  pcie_dbg_pkg::completer_id_t i_completer_id,
    input  pcie_dbg_pkg::cap_idx_t      i_count,
    output logic                        o_cnt_clr,
    output pcie_dbg_pkg::cap_idx_t      o_rd_idx,
    input  pcie_dbg_pkg::cap_data_t     i_rd_data
);
    import pcie_dbg_pkg::*;

    localparam apb_addr_t OFS_STATE = `PCIE_DBG_OFS_STATE;
    localparam apb_addr_t OFS_ID    = `PCIE_DBG_OFS_ID;
    localparam apb_addr_t OFS_COUNT = `PCIE_DBG_OFS_COUNT;
    localparam apb_addr_t BUF_BASE  = `PCIE_DBG_BUF_BASE;

    logic      hit_state;
    logic      hit_id;
    logic      hit_count;
    logic      hit_buf;
    apb_data_t rdata_d;
    logic      err_d;

    // Word decode, byte lanes ignored
    assign hit_state = (i_req.addr[11:2] == OFS_STATE[11:2]);
    assign hit_id    = (i_req.addr[11:2] == OFS_ID[11:2]);
    assign hit_count = (i_req.addr[11:2] == OFS_COUNT[11:2]);
    assign hit_buf   = (i_req.addr[11:7] == BUF_BASE[11:7]);  // 0x80..0xFF

    // Entry select, 8 bytes per slot
    assign o_rd_idx = i_req.addr[6:3];

    // Only the count register is writable
    assign o_cnt_clr = i_req.valid & i_req.write & hit_count;

    always_comb begin
        rdata_d = '0;
        err_d   = 1'b0;
        if (i_req.write) begin
            err_d = ~hit_count;      // Clear needs no data back
        end else if (hit_state) begin
            rdata_d = apb_data_t'(i_dma_state);
        end else if (hit_id) begin
            rdata_d = apb_data_t'(i_completer_id);
        end else if (hit_count) begin
            rdata_d = apb_data_t'(i_count);   // Pre-edge value
        end else if (hit_buf) begin
            // Address bit 2 picks the half
            rdata_d = i_req.addr[2] ? i_rd_data[63:32] : i_rd_data[31:0];
        end else begin
            err_d = 1'b1;            // Unmapped
        end
    end

    // Answer lands one cycle after the strobe
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp <= '0;
        end else begin
            o_resp.valid <= i_req.valid;
            o_resp.rdata <= rdata_d;
            o_resp.err   <= i_req.valid & err_d;
        end
    end

endmodule

//--- source/capture_buffer.sv
//##########################################################################
// Debug capture memory
//##########################################################################

`include "pcie_dbg_defs.svh"

module capture_buffer (
    input  logic                    i_clk,
    input  logic                    i_wr,
    input  pcie_dbg_pkg::cap_idx_t  i_wr_idx,
    input  pcie_dbg_pkg::cap_data_t i_wr_data,
    input  pcie_dbg_pkg::cap_idx_t  i_rd_idx,
    output pcie_dbg_pkg::cap_data_t o_rd_data
);
    import pcie_dbg_pkg::*;

    // Flop array, contents undefined until written
    cap_data_t mem [`PCIE_DBG_CAP_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            mem[i_wr_idx] <= i_wr_data;   // Slot named by counter
        end
    end

    // Async read, same-cycle write not visible yet
    assign o_rd_data = mem[i_rd_idx];

endmodule

//--- source/capture_counter.sv
//##########################################################################
// Capture index counter
//##########################################################################

module capture_counter (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_inc,   // Debug strobe
    input  logic                   i_clr,   // Count register write
    output pcie_dbg_pkg::cap_idx_t o_idx
);
    import pcie_dbg_pkg::*;

    cap_idx_t cnt_q;

    // Wraps 15 -> 0 by width, clear wins over increment
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt_q <= '0;
        end else if (i_clr) begin
            cnt_q <= '0;
        end else if (i_inc) begin
            cnt_q <= cnt_q + cap_idx_t'(1);
        end
    end

    // Write pointer and count value
    assign o_idx = cnt_q;

endmodule

//--- source/apb_slave_fsm.sv
//##########################################################################
// APB slave state machine
//##########################################################################

module apb_slave_fsm (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  pcie_dbg_pkg::apb_in_t  i_apb,
    output pcie_dbg_pkg::apb_out_t o_apb,
    output pcie_dbg_pkg::bus_req_t o_req,
    input  pcie_dbg_pkg::bus_resp_t i_resp
);
    import pcie_dbg_pkg::*;

    apb_state_e state_q;
    apb_state_e state_d;
    apb_addr_t  addr_q;    // Latched in setup phase
    logic       write_q;
    apb_data_t  wdata_q;
    logic       setup;

    // Setup phase seen from idle
    assign setup = i_apb.psel & ~i_apb.penable;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (setup) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ:  state_d = ST_WAIT;   // Strobe lasts one cycle
            ST_WAIT: begin
                if (i_resp.valid) begin
                    state_d = ST_IDLE;    // Transfer done
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Transfer payload held until the next setup
    always_ff @(posedge i_clk) begin
        if (state_q == ST_IDLE && setup) begin
            addr_q  <= i_apb.paddr;
            write_q <= i_apb.pwrite;
            wdata_q <= i_apb.pwdata;
        end
    end

    // Request toward decoder
    always_comb begin
        o_req.valid = (state_q == ST_REQ);
        o_req.addr  = addr_q;
        o_req.write = write_q;
        o_req.wdata = wdata_q;
    end

    // Response onto APB in the second access cycle
    always_comb begin
        o_apb.pready  = (state_q == ST_WAIT) & i_resp.valid;
        o_apb.prdata  = o_apb.pready ? i_resp.rdata : '0;
        o_apb.pslverr = o_apb.pready & i_resp.err;
    end

endmodule

//--- source/pcie_dbg_pkg.sv
//##########################################################################
// PCIe debug block types
//##########################################################################

`include "pcie_dbg_defs.svh"

package pcie_dbg_pkg;

    // Plain vectors
    typedef logic [`PCIE_DBG_ADDR_W-1:0] apb_addr_t;
    typedef logic [`PCIE_DBG_DATA_W-1:0] apb_data_t;
    typedef logic [`PCIE_DBG_CAP_W-1:0]  cap_data_t;
    typedef logic [`PCIE_DBG_IDX_W-1:0]  cap_idx_t;     // Slot index and count
    typedef logic [3:0]                  dma_state_t;   // Brief engine state
    typedef logic [15:0]                 completer_id_t; // Bus, device, function

    // APB master to slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_in_t;

    // APB slave to master
    typedef struct packed {
        logic      pready;
        apb_data_t prdata;
        logic      pslverr;
    } apb_out_t;

    // One-cycle request from FSM to decoder
    typedef struct packed {
        logic      valid;
        apb_addr_t addr;
        logic      write;
        apb_data_t wdata;
    } bus_req_t;

    // Registered answer, one cycle after request
    typedef struct packed {
        logic      valid;
        apb_data_t rdata;
        logic      err;
    } bus_resp_t;

    // Debug capture strobe from DMA side
    typedef struct packed {
        logic      valid;
        cap_data_t data;
    } dbg_req_t;

    // APB slave states
    typedef enum logic [1:0] {
        ST_IDLE,   // Waiting for setup phase
        ST_REQ,    // Request strobe out
        ST_WAIT    // Response back, PREADY high
    } apb_state_e;

endpackage

//--- source/pcie_dbg_defs.svh
//##########################################################################
// PCIe debug block widths and register map
//##########################################################################

`ifndef PCIE_DBG_DEFS_SVH
`define PCIE_DBG_DEFS_SVH

// Bus widths
`define PCIE_DBG_ADDR_W      12
`define PCIE_DBG_DATA_W      32

// Capture buffer geometry
`define PCIE_DBG_CAP_W       64
`define PCIE_DBG_CAP_DEPTH   16
`define PCIE_DBG_IDX_W       4     // log2 of depth

// Register word offsets
`define PCIE_DBG_OFS_STATE   12'h000  // DMA engine state
`define PCIE_DBG_OFS_ID      12'h004  // Completer ID
`define PCIE_DBG_OFS_COUNT   12'h008  // Capture count, write clears

// Buffer window 0x80..0xFF, low half at +0, high half at +4
`define PCIE_DBG_BUF_BASE    12'h080

`endif // PCIE_DBG_DEFS_SVH
